// File: source/mem_pkg.sv
//==========================================================================
// Memory access types
//==========================================================================

package mem_pkg;

  localparam int addr_w = 32;
  localparam int word_w = 32;
  localparam int byte_w = 8;

  typedef logic [addr_w-1:0] addr_t;  // only bits 17:0 reach the memory
  typedef logic [word_w-1:0] word_t;
  typedef logic [byte_w-1:0] byte_t;
  typedef logic [1:0]        byte_cnt_t;  // byte index inside one transfer

  // transfer length, little-endian from the base address
  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } access_size_e;

  typedef struct packed {
    addr_t        addr;
    word_t        wdata;
    access_size_e size;
    logic         write;
  } mem_req_t;

  // current owner of the bus
  typedef enum logic [1:0] {
    own_idle  = 2'd0,
    own_store = 2'd1,
    own_load  = 2'd2,
    own_fetch = 2'd3
  } owner_e;

  localparam logic [1:0] io_region_bits = 2'b11;  // addr[17:16] of the uart window

endpackage

// File: source/mem_arbiter.sv
//==========================================================================
// Memory bus arbiter
//==========================================================================
`timescale 1ns/1ps

module mem_arbiter
  import mem_pkg::*;
(
  input  logic         clk_in,
  input  logic         rst_in,
  input  logic         rdy_in,
  input  logic         flush,
  input  logic         fetch_req,
  input  addr_t        fetch_addr,
  input  logic         lsb_req,
  input  mem_req_t     lsb_cmd,
  input  logic         finish,
  input  word_t        rword,
  output logic         fetch_gr,
  output logic         fetch_done,
  output logic         lsb_gr,
  output logic         lsb_done,
  output word_t        fetch_word,
  output word_t        lsb_rdata,
  output logic         start,
  output owner_e       owner,
  output addr_t        xfer_addr,
  output word_t        xfer_wdata,
  output access_size_e xfer_size
);

  logic fetch_gr_q;
  logic lsb_gr_q;
  logic kill;
  logic done_ok;

  // stores always run to the end, only reads can be dropped
  assign kill    = flush && (owner == own_fetch || owner == own_load);
  assign done_ok = finish && rdy_in && !kill;

  assign fetch_gr   = fetch_gr_q && rdy_in;  // strobes only count in ready cycles
  assign lsb_gr     = lsb_gr_q && rdy_in;
  assign fetch_done = done_ok && (owner == own_fetch);
  assign lsb_done   = done_ok && (owner == own_store || owner == own_load);
  assign fetch_word = rword;
  assign lsb_rdata  = rword;

  always_ff @(posedge clk_in)
  begin
    if (rst_in)
    begin
      owner      <= own_idle;
      start      <= 1'b0;
      fetch_gr_q <= 1'b0;
      lsb_gr_q   <= 1'b0;
    end
    else if (kill)
    begin
      owner      <= own_idle;
      start      <= 1'b0;
      fetch_gr_q <= 1'b0;
      lsb_gr_q   <= 1'b0;
    end
    else if (rdy_in)
    begin
      start      <= 1'b0;
      fetch_gr_q <= 1'b0;
      lsb_gr_q   <= 1'b0;
      case (owner)
        own_idle:
        begin
          if (lsb_req)  // one lsb port, so store vs load is the command bit
          begin
            owner    <= lsb_cmd.write ? own_store : own_load;
            lsb_gr_q <= 1'b1;
            start    <= 1'b1;
          end
          else if (fetch_req)
          begin
            owner      <= own_fetch;
            fetch_gr_q <= 1'b1;
            start      <= 1'b1;
          end
        end
        default:
        begin
          if (finish)
            owner <= own_idle;
        end
      endcase
    end
  end

  // request contents, held for the whole transfer
  always_ff @(posedge clk_in)
  begin
    if (rdy_in && owner == own_idle)
    begin
      if (lsb_req)
      begin
        xfer_addr  <= lsb_cmd.addr;
        xfer_wdata <= lsb_cmd.wdata;
        xfer_size  <= lsb_cmd.size;
      end
      else if (fetch_req)
      begin
        xfer_addr  <= fetch_addr;
        xfer_wdata <= '0;
        xfer_size  <= size_word;  // instructions are always whole words
      end
    end
  end

endmodule

// File: source/mem_byte_engine.sv
//==========================================================================
// Byte-serial memory engine
//==========================================================================
`timescale 1ns/1ps

module mem_byte_engine
  import mem_pkg::*;
#(
  parameter int MEM_ADDR_BITS = 18
) (
  input  logic         clk_in,
  input  logic         rst_in,
  input  logic         rdy_in,
  input  logic         flush,
  input  logic         io_buffer_full,
  input  logic         start,
  input  owner_e       owner,
  input  addr_t        xfer_addr,
  input  word_t        xfer_wdata,
  input  access_size_e xfer_size,
  input  byte_t        mem_din,
  output byte_t        mem_dout,
  output addr_t        mem_a,
  output logic         mem_wr,
  output logic         finish,
  output word_t        rword
);

  localparam addr_t addr_mask = addr_t'((64'd1 << MEM_ADDR_BITS) - 64'd1);

  logic      busy;      // address phase running
  logic      tail;      // extra read cycle for the last returned byte
  byte_cnt_t cnt;
  byte_cnt_t last_idx;
  addr_t     base_addr;
  word_t     wdata_q;
  word_t     acc;
  logic      rd_valid;  // mem_din holds the byte asked for last cycle
  byte_cnt_t rd_idx;
  logic      is_store;
  logic      hold;
  logic      kill;
  logic      accept;
  addr_t     bus_addr;

  function automatic byte_cnt_t last_of(input access_size_e size);
    case (size)
      size_byte: return 2'd0;
      size_half: return 2'd1;
      default:   return 2'd3;
    endcase
  endfunction

  assign is_store = (owner == own_store);
  assign kill     = flush && !is_store;
  assign accept   = start && !busy && !tail && rdy_in && !kill;
  // uart window stores wait for room in the output buffer
  assign hold     = busy && is_store && (base_addr[17:16] == io_region_bits)
                    && io_buffer_full;
  assign bus_addr = base_addr + addr_t'(cnt);

  assign mem_a    = busy ? (bus_addr & addr_mask) : '0;
  assign mem_dout = wdata_q[{cnt, 3'b000} +: 8];
  assign mem_wr   = busy && is_store && !hold && rdy_in;
  assign finish   = tail || (busy && is_store && !hold && cnt == last_idx);

  always_ff @(posedge clk_in)
  begin
    if (rst_in)
    begin
      busy     <= 1'b0;
      tail     <= 1'b0;
      cnt      <= '0;
      rd_valid <= 1'b0;
    end
    else
    begin
      // tracks the memory even while paused, the returned byte is not repeated
      rd_valid <= busy && !is_store && rdy_in && !kill;
      if (kill)
      begin
        busy <= 1'b0;
        tail <= 1'b0;
      end
      else if (rdy_in)
      begin
        if (accept)
        begin
          busy <= 1'b1;
          cnt  <= '0;
        end
        else if (busy && !hold)
        begin
          if (cnt == last_idx)
          begin
            busy <= 1'b0;
            tail <= !is_store;  // reads wait one more cycle for data
          end
          else
            cnt <= cnt + 2'd1;
        end
        else if (tail)
          tail <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_in)
  begin
    rd_idx <= cnt;
    if (rd_valid)
      acc[{rd_idx, 3'b000} +: 8] <= mem_din;
    if (accept)
    begin
      base_addr <= xfer_addr;
      wdata_q   <= xfer_wdata;
      last_idx  <= last_of(xfer_size);
      acc       <= '0;  // short loads come back zero-extended
    end
  end

  // last byte goes straight through so the word is complete in the finish cycle
  always_comb
  begin
    rword = acc;
    if (rd_valid)
      rword[{rd_idx, 3'b000} +: 8] = mem_din;
  end

endmodule

// File: source/mem_ctrl.sv
//==========================================================================
// Memory controller top
//==========================================================================
`timescale 1ns/1ps

module mem_ctrl
  import mem_pkg::*;
#(
  parameter int MEM_ADDR_BITS = 18
) (
  input  logic     clk_in,
  input  logic     rst_in,
  input  logic     rdy_in,
  input  logic     flush,
  input  logic     io_buffer_full,
  input  logic     fetch_req,
  input  addr_t    fetch_addr,
  input  logic     lsb_req,
  input  mem_req_t lsb_cmd,
  input  byte_t    mem_din,
  output logic     fetch_gr,
  output logic     fetch_done,
  output logic     lsb_gr,
  output logic     lsb_done,
  output word_t    fetch_word,
  output word_t    lsb_rdata,
  output byte_t    mem_dout,
  output addr_t    mem_a,
  output logic     mem_wr
);

  logic         start;
  logic         finish;
  owner_e       owner;
  addr_t        xfer_addr;
  word_t        xfer_wdata;
  access_size_e xfer_size;
  word_t        rword;

  mem_arbiter u_arbiter (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .rdy_in     (rdy_in),
    .flush      (flush),
    .fetch_req  (fetch_req),
    .fetch_addr (fetch_addr),
    .lsb_req    (lsb_req),
    .lsb_cmd    (lsb_cmd),
    .finish     (finish),
    .rword      (rword),
    .fetch_gr   (fetch_gr),
    .fetch_done (fetch_done),
    .lsb_gr     (lsb_gr),
    .lsb_done   (lsb_done),
    .fetch_word (fetch_word),
    .lsb_rdata  (lsb_rdata),
    .start      (start),
    .owner      (owner),
    .xfer_addr  (xfer_addr),
    .xfer_wdata (xfer_wdata),
    .xfer_size  (xfer_size)
  );

  mem_byte_engine #(
    .MEM_ADDR_BITS (MEM_ADDR_BITS)
  ) u_engine (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .rdy_in         (rdy_in),
    .flush          (flush),
    .io_buffer_full (io_buffer_full),
    .start          (start),
    .owner          (owner),
    .xfer_addr      (xfer_addr),
    .xfer_wdata     (xfer_wdata),
    .xfer_size      (xfer_size),
    .mem_din        (mem_din),
    .mem_dout       (mem_dout),
    .mem_a          (mem_a),
    .mem_wr         (mem_wr),
    .finish         (finish),
    .rword          (rword)
  );

endmodule

// File: test/mem_ctrl_props.sv
//==========================================================================
// Arbiter protocol assertions
//==========================================================================
`timescale 1ns/1ps

module mem_ctrl_props
  import mem_pkg::*;
(
  input logic   clk_in,
  input logic   rst_in,
  input logic   rdy_in,
  input logic   fetch_gr,
  input logic   lsb_gr,
  input logic   fetch_done,
  input logic   lsb_done,
  input owner_e owner
);

  grant_pulse: assert property (@(posedge clk_in) disable iff (rst_in)
    (fetch_gr || lsb_gr) |=> !(fetch_gr || lsb_gr))
    else $error("grant wider than one cycle");

  done_pulse: assert property (@(posedge clk_in) disable iff (rst_in)
    (fetch_done || lsb_done) |=> !(fetch_done || lsb_done))
    else $error("done wider than one cycle");

  one_grant: assert property (@(posedge clk_in) disable iff (rst_in)
    !(fetch_gr && lsb_gr))
    else $error("fetch and lsb granted together");

  // a ready cycle with an owner clears any pending grant
  no_grant_busy: assert property (@(posedge clk_in) disable iff (rst_in)
    (owner != own_idle && rdy_in) |=> !(fetch_gr || lsb_gr))
    else $error("grant while a transfer is open");

endmodule

bind mem_arbiter mem_ctrl_props u_props (
  .clk_in     (clk_in),
  .rst_in     (rst_in),
  .rdy_in     (rdy_in),
  .fetch_gr   (fetch_gr),
  .lsb_gr     (lsb_gr),
  .fetch_done (fetch_done),
  .lsb_done   (lsb_done),
  .owner      (owner)
);

// File: test/tb_mem_ctrl.sv
//==========================================================================
// Memory controller testbench
//==========================================================================
`timescale 1ns/1ps

module tb_mem_ctrl
  import mem_pkg::*;
;

  localparam int n_lines    = 22;
  localparam int n_fields   = 10;
  localparam int clk_period = 20;
  localparam int max_cycles = n_lines * 40 + 100;

  logic     clk_in;
  logic     rst_in;
  logic     rdy_in;
  logic     flush;
  logic     io_buffer_full;
  logic     fetch_req;
  addr_t    fetch_addr;
  logic     lsb_req;
  mem_req_t lsb_cmd;
  byte_t    mem_din;
  logic     fetch_gr;
  logic     fetch_done;
  logic     lsb_gr;
  logic     lsb_done;
  word_t    fetch_word;
  word_t    lsb_rdata;
  byte_t    mem_dout;
  addr_t    mem_a;
  logic     mem_wr;

  logic [31:0] trace_mem [0:n_lines*n_fields-1];
  byte_t       mem [0:131071];  // address bit 17 is not decoded
  int          errors;
  integer      seed;

  mem_ctrl #(
    .MEM_ADDR_BITS (18)
  ) DUT (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .rdy_in         (rdy_in),
    .flush          (flush),
    .io_buffer_full (io_buffer_full),
    .fetch_req      (fetch_req),
    .fetch_addr     (fetch_addr),
    .lsb_req        (lsb_req),
    .lsb_cmd        (lsb_cmd),
    .mem_din        (mem_din),
    .fetch_gr       (fetch_gr),
    .fetch_done     (fetch_done),
    .lsb_gr         (lsb_gr),
    .lsb_done       (lsb_done),
    .fetch_word     (fetch_word),
    .lsb_rdata      (lsb_rdata),
    .mem_dout       (mem_dout),
    .mem_a          (mem_a),
    .mem_wr         (mem_wr)
  );

  always #(clk_period/2) clk_in = ~clk_in;

  // byte comes back one clock after its address
  always @(posedge clk_in)
  begin
    if (mem_wr)
      mem[mem_a[16:0]] <= mem_dout;
    mem_din <= mem[mem_a[16:0]];
  end

  task automatic check(input string name, input word_t exp, input word_t act);
    if (exp !== act)
    begin
      errors++;
      $display("Fail %s: expected %h, got %h", name, exp, act);
    end
  endtask

  task automatic report(input string what);
    errors++;
    $display("%s at %0t", what, $time);
  endtask

  // one request from grant to done
  task automatic run_xfer(input logic is_fetch, input logic write, input addr_t addr,
                          input access_size_e size, input word_t wdata, input int pause,
                          input int iofull, input logic flush_en, input word_t exp,
                          input logic with_fetch);
    int   n;
    int   lat;
    int   p;
    int   c;
    int   done_c;
    int   wait_n;
    int   wr_n;
    logic gr;
    logic dn;
    logic other_gr;
    n = (size == size_byte) ? 1 : (size == size_half) ? 2 : 4;
    lat = write ? n : n + 1;
    p = 1 + int'($unsigned($random(seed)) % n);
    @(negedge clk_in);
    if (is_fetch)
    begin
      fetch_req  = 1'b1;
      fetch_addr = addr;
    end
    else
    begin
      lsb_req = 1'b1;
      lsb_cmd = '{addr: addr, wdata: wdata, size: size, write: write};
      if (with_fetch)
        fetch_req = 1'b1;
    end
    #1;
    wait_n = 0;
    gr = is_fetch ? fetch_gr : lsb_gr;
    while (!gr && wait_n < 10)
    begin
      if (is_fetch ? lsb_gr : fetch_gr)
        report("wrong client granted");
      @(negedge clk_in);
      #1;
      wait_n++;
      gr = is_fetch ? fetch_gr : lsb_gr;
    end
    if (!gr)
    begin
      report("request was never granted");
      return;
    end
    if (is_fetch)
      fetch_req = 1'b0;
    else
      lsb_req = 1'b0;
    c = 0;
    done_c = -1;
    wr_n = 0;
    while (done_c < 0 && c < lat + pause + iofull + 8)
    begin
      @(negedge clk_in);
      c++;
      rdy_in         = !(pause > 0 && c >= p && c < p + pause);
      io_buffer_full = (c >= 1 && c <= iofull);
      flush          = flush_en && (c == 2);
      #1;
      other_gr = is_fetch ? lsb_gr : fetch_gr;
      dn       = is_fetch ? fetch_done : lsb_done;
      if (other_gr)
        report("second grant while a transfer was open");
      if (io_buffer_full && mem_wr)
        report("memory written while the I/O buffer was full");
      if (is_fetch ? lsb_done : fetch_done)
        report("done strobe for the wrong client");
      if (mem_wr)
      begin
        if (is_fetch || !write)
          report("memory written during a read");
        else
        begin
          check("mem_a", addr + addr_t'(wr_n), mem_a);
          check("mem_dout", word_t'(wdata[8*wr_n +: 8]), word_t'(mem_dout));
          wr_n++;
        end
      end
      if (dn)
      begin
        done_c = c;
        if (is_fetch)
          check("fetch_word", exp, fetch_word);
        else if (!write)
          check("lsb_rdata", exp, lsb_rdata);
        else
          check("mem_wr count", word_t'(n), word_t'(wr_n));
      end
    end
    rdy_in         = 1'b1;
    io_buffer_full = 1'b0;
    flush          = 1'b0;
    if (flush_en && (is_fetch || !write))
    begin
      if (done_c >= 0)
        report("done raised for a flushed transfer");
    end
    else if (done_c < 0)
      report("transfer never signalled done");
    else
      check("done cycle", word_t'(lat + pause + iofull), word_t'(done_c));
  endtask

  initial
  begin
    int    kind;
    int    b;
    word_t f [0:n_fields-1];
    clk_in         = 1'b0;
    rst_in         = 1'b1;
    rdy_in         = 1'b1;
    flush          = 1'b0;
    io_buffer_full = 1'b0;
    fetch_req      = 1'b0;
    fetch_addr     = '0;
    lsb_req        = 1'b0;
    lsb_cmd        = '0;
    errors         = 0;
    seed           = 32'h8df4_dadc;
    for (int i = 0; i < 131072; i++)
      mem[i] = byte_t'(i[7:0] ^ i[15:8] ^ {7'd0, i[16]});
    $readmemh("test/mem_trace.txt", trace_mem);
    repeat (2) @(posedge clk_in);
    @(negedge clk_in);
    check("fetch_gr", '0, word_t'(fetch_gr));
    check("lsb_gr", '0, word_t'(lsb_gr));
    check("fetch_done", '0, word_t'(fetch_done));
    check("lsb_done", '0, word_t'(lsb_done));
    check("mem_wr", '0, word_t'(mem_wr));
    rst_in = 1'b0;
    for (int l = 0; l < n_lines; l++)
    begin
      b = l * n_fields;
      for (int k = 0; k < n_fields; k++)
        f[k] = trace_mem[b + k];
      kind = int'(f[0]);
      if (kind == 0)
        run_xfer(1'b1, 1'b0, f[1], size_word, '0, int'(f[4]), 0, f[6][0], f[7], 1'b0);
      else
      begin
        if (kind >= 3)
          fetch_addr = f[8];  // valid before the held fetch request rises
        run_xfer(1'b0, kind == 2 || kind == 4, f[1], access_size_e'(f[2][1:0]), f[3],
                 int'(f[4]), int'(f[5]), f[6][0], f[7], kind >= 3);
        if (kind >= 3)  // fetch was held and is granted after lsb_done
          run_xfer(1'b1, 1'b0, f[8], size_word, '0, 0, 0, 1'b0, f[9], 1'b0);
      end
    end
    repeat (3) @(negedge clk_in);
    $display("run finished with %0d errors", errors);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

  initial
  begin
    repeat (max_cycles) @(posedge clk_in);
    $display("timeout, the trace did not finish in %0d cycles", max_cycles);
    $display(">>> FAIL");
    $finish;
  end

endmodule

// File: test/mem_trace.txt
// kind(0 fetch 1 load 2 store 3 load+fetch 4 store+fetch) addr size wdata
// rdy_low_cycles io_full_cycles flush exp_lsb fetch_addr exp_fetch
0 00000000 2 00000000 0 0 0 03020100 00000000 00000000
0 00001234 2 00000000 0 0 0 25242726 00000000 00000000
2 00000200 0 000000a5 0 0 0 00000000 00000000 00000000
1 00000200 0 00000000 0 0 0 000000a5 00000000 00000000
2 00000302 1 0000beef 0 0 0 00000000 00000000 00000000
1 00000302 1 00000000 0 0 0 0000beef 00000000 00000000
2 00000400 2 12345678 0 0 0 00000000 00000000 00000000
1 00000400 2 00000000 0 0 0 12345678 00000000 00000000
1 00000500 2 00000000 0 0 0 06070405 00000000 00000000
3 00000400 2 00000000 0 0 0 12345678 00000000 03020100
4 00000600 1 00001111 0 0 0 00000000 00001234 25242726
2 00000700 2 cafef00d 3 0 0 00000000 00000000 00000000
1 00000700 2 00000000 2 0 0 cafef00d 00000000 00000000
0 00001234 2 00000000 4 0 0 25242726 00000000 00000000
1 00000201 0 00000000 1 0 0 00000003 00000000 00000000
2 00030000 2 00000041 0 3 0 00000000 00000000 00000000
1 00030000 2 00000000 0 0 0 00000041 00000000 00000000
0 00000000 2 00000000 0 0 1 00000000 00000000 00000000
1 00000400 2 00000000 0 0 1 00000000 00000000 00000000
2 00000800 2 deadbeef 0 0 1 00000000 00000000 00000000
1 00000800 2 00000000 0 0 0 deadbeef 00000000 00000000
0 00000000 2 00000000 0 0 0 03020100 00000000 00000000

// File: verilog.f
source/mem_pkg.sv
source/mem_arbiter.sv
source/mem_byte_engine.sv
source/mem_ctrl.sv
test/mem_ctrl_props.sv
test/tb_mem_ctrl.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_ctrl
FLIST     ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q '>>> FAIL' $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
